//--- noc_pkg.sv
/*
 * Mesh network definitions shared by the core complex.
 * Tile coordinate, flit and ready-and link structs, endpoint
 * opcodes and the router port directions.
 */
package noc_pkg;

  // Width of one coordinate field.
  localparam int cord_width_lp = 2;

  // Column 0 belongs to the host.
  typedef struct packed
  {
    logic [cord_width_lp-1:0] x;
    logic [cord_width_lp-1:0] y;
  } cord_s;

  typedef enum logic [1:0]
  {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    OP_ADD   = 2'd2,
    OP_RESP  = 2'd3
  } op_e;

  // Single-flit packet.
  typedef struct packed
  {
    cord_s       dst;
    cord_s       src;
    op_e         op;
    logic [3:0]  tag;
    logic [1:0]  addr;
    logic [11:0] data;
  } flit_s;

  // Ready returns to the far side in the same struct.
  typedef struct packed
  {
    logic  v;
    flit_s flit;
    logic  ready_and_rev;
  } link_s;

  // Router port indices.
  typedef enum logic [2:0]
  {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

endpackage

//--- mesh_router.sv
/*
 * Five-port dimension-ordered mesh router.
 * One-entry input buffers, XY route per buffer head and a
 * round-robin arbiter with grant lock on every output.
 */
`timescale 1ns/100ps

module mesh_router
  (input  logic                                      core_clk_i
  ,input  logic                                      rst_n_i
  ,input  noc_pkg::cord_s                            my_cord_i
  ,input  noc_pkg::link_s [noc_pkg::S : noc_pkg::P]  link_i
  ,output noc_pkg::link_s [noc_pkg::S : noc_pkg::P]  link_o
  );

  localparam int ports_lp = 5;

  // X first, then Y.
  function automatic noc_pkg::dir_e xy_route(input noc_pkg::cord_s my_cord
                                            ,input noc_pkg::cord_s dst_cord);
    noc_pkg::dir_e dir;
    if (dst_cord.x > my_cord.x)
      dir = noc_pkg::E;
    else if (dst_cord.x < my_cord.x)
      dir = noc_pkg::W;
    else if (dst_cord.y > my_cord.y)
      dir = noc_pkg::S;
    else if (dst_cord.y < my_cord.y)
      dir = noc_pkg::N;
    else
      dir = noc_pkg::P;
    return dir;
  endfunction

  // Turns that XY routing allows.
  // Keeps the ready paths between routers free of loops.
  function automatic logic turn_ok(input int in_port, input int out_port);
    logic ok;
    case (in_port)
      noc_pkg::W: ok = (out_port != noc_pkg::W);
      noc_pkg::E: ok = (out_port != noc_pkg::E);
      noc_pkg::N: ok = (out_port == noc_pkg::S) || (out_port == noc_pkg::P);
      noc_pkg::S: ok = (out_port == noc_pkg::N) || (out_port == noc_pkg::P);
      default:    ok = (out_port != noc_pkg::P);
    endcase
    return ok;
  endfunction

  logic           [ports_lp-1:0]               buf_v_r;
  noc_pkg::flit_s [ports_lp-1:0]               buf_flit_r;
  logic           [ports_lp-1:0]               in_v;
  logic           [ports_lp-1:0]               in_rdy;
  logic           [ports_lp-1:0]               sent;
  logic           [ports_lp-1:0][ports_lp-1:0] req;
  logic           [ports_lp-1:0]               out_v;
  logic           [ports_lp-1:0]               lock_r;
  logic           [2:0]                        sel     [ports_lp];
  logic           [2:0]                        sel_r   [ports_lp];
  logic           [2:0]                        ptr_r   [ports_lp];

  // ************************************************************************
  // Route and request.
  // ************************************************************************
  always_comb
  begin
    for (int o = 0; o < ports_lp; o++)
      for (int i = 0; i < ports_lp; i++)
        req[o][i] = buf_v_r[i]
                    && (int'(xy_route(my_cord_i, buf_flit_r[i].dst)) == o)
                    && turn_ok(i, o);
  end

  // Rotating priority, held while the winner waits on ready.
  always_comb
  begin
    logic       found;
    logic [2:0] pick;
    int         idx;
    for (int o = 0; o < ports_lp; o++)
    begin
      found = 1'b0;
      pick  = ptr_r[o];
      for (int k = 0; k < ports_lp; k++)
      begin
        idx = int'(ptr_r[o]) + k;
        if (idx >= ports_lp)
          idx = idx - ports_lp;
        if (!found && req[o][idx])
        begin
          found = 1'b1;
          pick  = 3'(idx);
        end
      end
      out_v[o] = found;
      sel[o]   = lock_r[o] ? sel_r[o] : pick;
    end
  end

  // Head leaves when its output transfers.
  always_comb
  begin
    sent = '0;
    for (int o = 0; o < ports_lp; o++)
      if (out_v[o] && link_i[o].ready_and_rev)
        sent[sel[o]] = 1'b1;
    for (int i = 0; i < ports_lp; i++)
      in_v[i] = link_i[i].v;
    in_rdy = ~buf_v_r | sent;
  end

  always_comb
  begin
    for (int o = 0; o < ports_lp; o++)
    begin
      link_o[o].v             = out_v[o];
      link_o[o].flit          = buf_flit_r[sel[o]];
      link_o[o].ready_and_rev = in_rdy[o];
    end
  end

  // ************************************************************************
  // State.
  // ************************************************************************
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      buf_v_r <= '0;
      lock_r  <= '0;
      for (int o = 0; o < ports_lp; o++)
      begin
        sel_r[o] <= '0;
        ptr_r[o] <= '0;
      end
    end
    else
    begin
      buf_v_r <= (in_v & in_rdy) | (buf_v_r & ~sent);
      for (int o = 0; o < ports_lp; o++)
      begin
        lock_r[o] <= out_v[o] & ~link_i[o].ready_and_rev;
        sel_r[o]  <= sel[o];
        if (out_v[o] && link_i[o].ready_and_rev)
          ptr_r[o] <= (sel[o] == 3'd4) ? 3'd0 : sel[o] + 3'd1;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    for (int i = 0; i < ports_lp; i++)
      if (in_v[i] && in_rdy[i])
        buf_flit_r[i] <= link_i[i].flit;
  end

endmodule

//--- tile_endpoint.sv
/*
 * Register endpoint of a tile.
 * Executes write, read and add requests on four registers
 * and returns one response flit to the sender.
 */
`timescale 1ns/100ps

module tile_endpoint
  (input  logic           core_clk_i
  ,input  logic           rst_n_i
  ,input  noc_pkg::cord_s my_cord_i
  ,input  noc_pkg::link_s req_link_i
  ,output noc_pkg::link_s resp_link_o
  );

  logic [11:0]    rf_r [4];
  logic           resp_v_r;
  noc_pkg::flit_s resp_flit_r;
  noc_pkg::flit_s req_flit;
  logic           req_fire;
  logic [11:0]    result;

  assign req_flit = req_link_i.flit;
  assign req_fire = req_link_i.v & ~resp_v_r;

  // Sum wraps at 12 bits.
  always_comb
  begin
    case (req_flit.op)
      noc_pkg::OP_WRITE: result = req_flit.data;
      noc_pkg::OP_ADD:   result = rf_r[req_flit.addr] + req_flit.data;
      default:           result = rf_r[req_flit.addr];
    endcase
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
      for (int r = 0; r < 4; r++)
        rf_r[r] <= '0;
    end
    else if (req_fire && (req_flit.op != noc_pkg::OP_RESP))
    begin
      resp_v_r <= 1'b1;
      if (req_flit.op != noc_pkg::OP_READ)
        rf_r[req_flit.addr] <= result;
    end
    else if (resp_v_r && req_link_i.ready_and_rev)
      resp_v_r <= 1'b0;
  end

  // Reply goes back to the requester.
  always_ff @(posedge core_clk_i)
  begin
    if (req_fire)
    begin
      resp_flit_r.dst  <= req_flit.src;
      resp_flit_r.src  <= my_cord_i;
      resp_flit_r.op   <= noc_pkg::OP_RESP;
      resp_flit_r.tag  <= req_flit.tag;
      resp_flit_r.addr <= req_flit.addr;
      resp_flit_r.data <= result;
    end
  end

  assign resp_link_o.v             = resp_v_r;
  assign resp_link_o.flit          = resp_flit_r;
  assign resp_link_o.ready_and_rev = ~resp_v_r;

endmodule

//--- tile_node.sv
/*
 * One mesh tile.
 * XY router with the register endpoint on its local port.
 */
`timescale 1ns/100ps

module tile_node
  (input  logic                                      core_clk_i
  ,input  logic                                      rst_n_i
  ,input  noc_pkg::cord_s                            my_cord_i
  ,input  noc_pkg::link_s [noc_pkg::S : noc_pkg::W]  link_i
  ,output noc_pkg::link_s [noc_pkg::S : noc_pkg::W]  link_o
  );

  noc_pkg::link_s [noc_pkg::S : noc_pkg::P] rtr_link_li;
  noc_pkg::link_s [noc_pkg::S : noc_pkg::P] rtr_link_lo;
  noc_pkg::link_s                           ep_req_link;
  noc_pkg::link_s                           ep_resp_link;

  // Mesh ports pass straight to the router.
  assign rtr_link_li[noc_pkg::S : noc_pkg::W] = link_i;
  assign link_o = rtr_link_lo[noc_pkg::S : noc_pkg::W];

  // Local port.
  assign rtr_link_li[noc_pkg::P] = ep_resp_link;
  assign ep_req_link             = rtr_link_lo[noc_pkg::P];

  mesh_router router
    (.core_clk_i (core_clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.my_cord_i  (my_cord_i)
    ,.link_i     (rtr_link_li)
    ,.link_o     (rtr_link_lo)
    );

  tile_endpoint endpoint
    (.core_clk_i  (core_clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.my_cord_i   (my_cord_i)
    ,.req_link_i  (ep_req_link)
    ,.resp_link_o (ep_resp_link)
    );

endmodule

//--- mesh_stitch.sv
/*
 * Mesh stitching for any link type.
 * Joins each tile port to its neighbour or to the edge ports.
 */
`timescale 1ns/100ps

module mesh_stitch
  #(parameter type link_t  = logic
   ,parameter int  x_dim_p = 2
   ,parameter int  y_dim_p = 2
   )
  (input  link_t [y_dim_p-1:0][x_dim_p-1:0][noc_pkg::S : noc_pkg::W] outs_i
  ,output link_t [y_dim_p-1:0][x_dim_p-1:0][noc_pkg::S : noc_pkg::W] ins_o
  ,input  link_t [noc_pkg::E : noc_pkg::W][y_dim_p-1:0]              hor_i
  ,output link_t [noc_pkg::E : noc_pkg::W][y_dim_p-1:0]              hor_o
  ,input  link_t [noc_pkg::S : noc_pkg::N][x_dim_p-1:0]              ver_i
  ,output link_t [noc_pkg::S : noc_pkg::N][x_dim_p-1:0]              ver_o
  );

  // The whole link crosses, so every ready returns to its sender.
  for (genvar y = 0; y < y_dim_p; y++)
  begin : row
    assign hor_o[noc_pkg::W][y] = outs_i[y][0][noc_pkg::W];
    assign hor_o[noc_pkg::E][y] = outs_i[y][x_dim_p-1][noc_pkg::E];

    for (genvar x = 0; x < x_dim_p; x++)
    begin : col
      if (x == 0)
        assign ins_o[y][x][noc_pkg::W] = hor_i[noc_pkg::W][y];
      else
        assign ins_o[y][x][noc_pkg::W] = outs_i[y][x-1][noc_pkg::E];

      if (x == x_dim_p-1)
        assign ins_o[y][x][noc_pkg::E] = hor_i[noc_pkg::E][y];
      else
        assign ins_o[y][x][noc_pkg::E] = outs_i[y][x+1][noc_pkg::W];

      // Row 0 is the north edge.
      if (y == 0)
        assign ins_o[y][x][noc_pkg::N] = ver_i[noc_pkg::N][x];
      else
        assign ins_o[y][x][noc_pkg::N] = outs_i[y-1][x][noc_pkg::S];

      if (y == y_dim_p-1)
        assign ins_o[y][x][noc_pkg::S] = ver_i[noc_pkg::S][x];
      else
        assign ins_o[y][x][noc_pkg::S] = outs_i[y+1][x][noc_pkg::N];
    end
  end

  for (genvar x = 0; x < x_dim_p; x++)
  begin : edge_col
    assign ver_o[noc_pkg::N][x] = outs_i[0][x][noc_pkg::N];
    assign ver_o[noc_pkg::S][x] = outs_i[y_dim_p-1][x][noc_pkg::S];
  end

endmodule

//--- core_complex.sv
/*
 * Core complex top level.
 * Grid of tiles on one mesh network with full edge links.
 * Column 0 is left to the host on the west edge.
 */
`timescale 1ns/100ps

module core_complex
  #(parameter int x_dim_p = 2
   ,parameter int y_dim_p = 2
   )
  (input  logic                                                    core_clk_i
  ,input  logic                                                    rst_n_i
  ,input  noc_pkg::link_s [noc_pkg::E : noc_pkg::W][y_dim_p-1:0]  hor_link_i
  ,output noc_pkg::link_s [noc_pkg::E : noc_pkg::W][y_dim_p-1:0]  hor_link_o
  ,input  noc_pkg::link_s [noc_pkg::S : noc_pkg::N][x_dim_p-1:0]  ver_link_i
  ,output noc_pkg::link_s [noc_pkg::S : noc_pkg::N][x_dim_p-1:0]  ver_link_o
  );

  noc_pkg::link_s [y_dim_p-1:0][x_dim_p-1:0][noc_pkg::S : noc_pkg::W] tile_link_lo;
  noc_pkg::link_s [y_dim_p-1:0][x_dim_p-1:0][noc_pkg::S : noc_pkg::W] tile_link_li;

  // ************************************************************************
  // Tile grid.
  // ************************************************************************
  for (genvar row = 0; row < y_dim_p; row++)
  begin : y
    for (genvar col = 0; col < x_dim_p; col++)
    begin : x
      noc_pkg::cord_s cord_li;

      // Tiles start at column 1.
      assign cord_li.x = noc_pkg::cord_width_lp'(col + 1);
      assign cord_li.y = noc_pkg::cord_width_lp'(row);

      tile_node tile
        (.core_clk_i (core_clk_i)
        ,.rst_n_i    (rst_n_i)
        ,.my_cord_i  (cord_li)
        ,.link_i     (tile_link_li[row][col])
        ,.link_o     (tile_link_lo[row][col])
        );
    end
  end

  // ************************************************************************
  // Mesh wiring.
  // ************************************************************************
  mesh_stitch
    #(.link_t  (noc_pkg::link_s)
     ,.x_dim_p (x_dim_p)
     ,.y_dim_p (y_dim_p)
     )
  mesh
    (.outs_i (tile_link_lo)
    ,.ins_o  (tile_link_li)
    ,.hor_i  (hor_link_i)
    ,.hor_o  (hor_link_o)
    ,.ver_i  (ver_link_i)
    ,.ver_o  (ver_link_o)
    );

endmodule

//--- core_complex_sva.sv
/*
 * Link protocol assertions for the mesh router.
 * Bound into every router instance.
 */
`timescale 1ns/100ps

module core_complex_sva
  (input logic                                     core_clk_i
  ,input logic                                     rst_n_i
  ,input noc_pkg::link_s [noc_pkg::S : noc_pkg::P] link_i
  ,input noc_pkg::link_s [noc_pkg::S : noc_pkg::P] link_o
  );

  for (genvar o = 0; o < 5; o++)
  begin : port
    // A stalled flit waits unchanged for ready.
    hold_until_ready: assert property
      (@(posedge core_clk_i) disable iff (!rst_n_i)
        link_o[o].v && !link_i[o].ready_and_rev
        |=> link_o[o].v && $stable(link_o[o].flit))
      else $error("router output %0d dropped or changed a stalled flit", o);

    quiet_in_reset: assert property
      (@(posedge core_clk_i) !rst_n_i |-> !link_o[o].v)
      else $error("router output %0d is valid during reset", o);
  end

endmodule

bind mesh_router core_complex_sva router_sva
  (.core_clk_i (core_clk_i)
  ,.rst_n_i    (rst_n_i)
  ,.link_i     (link_i)
  ,.link_o     (link_o)
  );

//--- tb_core_complex.sv
/*
 * Testbench for the core complex mesh.
 * West edge hosts replay the pattern records under random
 * ready, a scoreboard per sender row and tile checks each
 * response, and the other edges are watched for traffic.
 */
`timescale 1ns/100ps

module tb_core_complex;

  localparam int x_dim_lp        = 2;
  localparam int y_dim_lp        = 2;
  localparam int clk_period_lp   = 40;
  localparam int rec_max_lp      = 64;
  localparam int quiet_cycles_lp = 20;

  // Pattern record, one hex word per line.
  typedef struct packed
  {
    logic [3:0]     test;
    logic [3:0]     row;
    noc_pkg::flit_s flit;
    logic [11:0]    exp_data;
  } rec_s;

  logic core_clk = 1'b0;
  logic rst_n    = 1'b0;

  noc_pkg::link_s [noc_pkg::E : noc_pkg::W][y_dim_lp-1:0] hor_li;
  noc_pkg::link_s [noc_pkg::E : noc_pkg::W][y_dim_lp-1:0] hor_lo;
  noc_pkg::link_s [noc_pkg::S : noc_pkg::N][x_dim_lp-1:0] ver_li;
  noc_pkg::link_s [noc_pkg::S : noc_pkg::N][x_dim_lp-1:0] ver_lo;

  logic [47:0]    rec_mem [rec_max_lp];
  int             rec_cnt     = 0;
  logic           loaded      = 1'b0;
  integer         seed        = 32'h70c1c7db;
  int             errors      = 0;
  int             edge_errors = 0;
  int             checks      = 0;
  int             sent_cnt    = 0;
  int             resp_cnt    = 0;
  int             stall_cnt   = 0;
  // Keyed by sender row and tile coordinate.
  noc_pkg::flit_s exp_q [64][$];

  always #(clk_period_lp/2) core_clk = ~core_clk;

  core_complex
    #(.x_dim_p (x_dim_lp)
     ,.y_dim_p (y_dim_lp)
     )
  core_complex_i
    (.core_clk_i (core_clk)
    ,.rst_n_i    (rst_n)
    ,.hor_link_i (hor_li)
    ,.hor_link_o (hor_lo)
    ,.ver_link_i (ver_li)
    ,.ver_link_o (ver_lo)
    );

  task automatic print_result(input int id, input string name, input int errs);
    $display("test %0d (%s): %0d errors", id, name, errs);
  endtask

  task automatic verify_reset_state();
    for (int r = 0; r < y_dim_lp; r++)
      for (int d = int'(noc_pkg::W); d <= int'(noc_pkg::E); d++)
      begin
        checks++;
        assert (!hor_lo[d][r].v && hor_lo[d][r].ready_and_rev)
        else
        begin
          errors++;
          $display("FAILED at %0t: edge port %0d of row %0d not idle and ready", $time, d, r);
        end
      end
    for (int c = 0; c < x_dim_lp; c++)
      for (int d = int'(noc_pkg::N); d <= int'(noc_pkg::S); d++)
      begin
        checks++;
        assert (!ver_lo[d][c].v && ver_lo[d][c].ready_and_rev)
        else
        begin
          errors++;
          $display("FAILED at %0t: edge port %0d of column %0d not idle and ready",
                   $time, d, c);
        end
      end
  endtask

  // Only the west edge may carry traffic.
  task automatic watch_edges();
    for (int r = 0; r < y_dim_lp; r++)
      assert (!hor_lo[noc_pkg::E][r].v)
      else
      begin
        edge_errors++;
        $display("FAILED at %0t: east edge of row %0d carries a flit", $time, r);
      end
    for (int c = 0; c < x_dim_lp; c++)
      assert (!ver_lo[noc_pkg::N][c].v && !ver_lo[noc_pkg::S][c].v)
      else
      begin
        edge_errors++;
        $display("FAILED at %0t: vertical edge of column %0d carries a flit", $time, c);
      end
  endtask

  // Oldest request from that row to that tile must match.
  task automatic take_response(input int row, input noc_pkg::flit_s got);
    noc_pkg::flit_s exp_flit;
    int             key;
    key = int'({got.dst.y, got.src});
    resp_cnt++;
    checks++;
    assert (exp_q[key].size() != 0)
    else
    begin
      errors++;
      $display("response %h on row %0d at %0t matches no waiting request", got, row, $time);
    end
    if (exp_q[key].size() != 0)
    begin
      exp_flit = exp_q[key].pop_front();
      // XY routing sends a response out on the tile's own row.
      assert (got == exp_flit && row == int'(exp_flit.src.y))
      else
      begin
        errors++;
        $display("FAILED at %0t: row %0d got %h, expected %h on row %0d",
                 $time, row, got, exp_flit, exp_flit.src.y);
      end
    end
  endtask

  task automatic run_records(input int id);
    int             pos  [y_dim_lp];
    logic           busy [y_dim_lp];
    rec_s           rec;
    noc_pkg::flit_s exp_flit;
    int             pending;
    for (int r = 0; r < y_dim_lp; r++)
    begin
      pos[r]  = 0;
      busy[r] = 1'b0;
    end
    do
    begin
      @(negedge core_clk);
      for (int r = 0; r < y_dim_lp; r++)
      begin
        while (!busy[r] && pos[r] < rec_cnt)
        begin
          rec = rec_s'(rec_mem[pos[r]]);
          pos[r]++;
          if (int'(rec.test) == id && int'(rec.row) == r)
          begin
            exp_flit      = rec.flit;
            exp_flit.dst  = rec.flit.src;
            exp_flit.src  = rec.flit.dst;
            exp_flit.op   = noc_pkg::OP_RESP;
            exp_flit.data = rec.exp_data;
            exp_q[int'({exp_flit.dst.y, exp_flit.src})].push_back(exp_flit);
            hor_li[noc_pkg::W][r].flit = rec.flit;
            busy[r] = 1'b1;
            sent_cnt++;
          end
        end
        hor_li[noc_pkg::W][r].v             = busy[r];
        hor_li[noc_pkg::W][r].ready_and_rev = (($random(seed) & 3) != 0);
      end
      // Settled until the next rising edge.
      #(clk_period_lp/4);
      pending = sent_cnt - resp_cnt;
      for (int r = 0; r < y_dim_lp; r++)
      begin
        if (busy[r] && hor_lo[noc_pkg::W][r].ready_and_rev)
          busy[r] = 1'b0;
        if (hor_lo[noc_pkg::W][r].v && hor_li[noc_pkg::W][r].ready_and_rev)
          take_response(r, hor_lo[noc_pkg::W][r].flit);
        else if (hor_lo[noc_pkg::W][r].v)
          stall_cnt++;
        pending += int'(busy[r]) + int'(pos[r] < rec_cnt);
      end
      watch_edges();
    end
    while (pending != 0);
  endtask

  // No response may follow the last expected one.
  task automatic watch_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge core_clk);
      for (int r = 0; r < y_dim_lp; r++)
      begin
        hor_li[noc_pkg::W][r].v             = 1'b0;
        hor_li[noc_pkg::W][r].ready_and_rev = 1'b1;
      end
      #(clk_period_lp/4);
      for (int r = 0; r < y_dim_lp; r++)
        if (hor_lo[noc_pkg::W][r].v)
          take_response(r, hor_lo[noc_pkg::W][r].flit);
      watch_edges();
    end
  endtask

  initial
  begin
    wait (loaded);
    repeat (rec_cnt * 200) @(posedge core_clk);
    $display("watchdog expired after %0d cycles, %0d responses missing",
             rec_cnt * 200, sent_cnt - resp_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    int e;
    hor_li = '0;
    ver_li = '0;
    for (int i = 0; i < rec_max_lp; i++)
      rec_mem[i] = '0;
    $readmemh("core_complex_patterns.hex", rec_mem);
    while (rec_cnt < rec_max_lp && rec_mem[rec_cnt][47:44] != 4'd0)
      rec_cnt++;
    loaded = 1'b1;
    repeat (2) @(negedge core_clk);
    rst_n = 1'b1;
    #(clk_period_lp/4);
    e = errors;
    verify_reset_state();
    print_result(1, "reset state", errors - e);
    e = errors;
    run_records(2);
    print_result(2, "write and read", errors - e);
    e = errors;
    run_records(3);
    print_result(3, "add", errors - e);
    e = errors;
    watch_quiet(quiet_cycles_lp);
    checks += 2;
    assert (sent_cnt == rec_cnt && resp_cnt == sent_cnt)
    else
    begin
      errors++;
      $display("FAILED at %0t: %0d responses for %0d requests", $time, resp_cnt, sent_cnt);
    end
    assert (stall_cnt > 0)
    else
    begin
      errors++;
      $display("host back-pressure never held a response");
    end
    print_result(4, "back-pressure", errors - e);
    print_result(5, "edges idle", edge_errors);
    errors += edge_errors;
    $display("%0d tests, %0d checks, %0d errors", 5, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- core_complex_patterns.hex
// test_row_flit_expected: test, host row, flit (dst src op/tag/addr data), response data
// tile cords 4=(1,0) 5=(1,1) 8=(2,0) 9=(2,1); a test field of 0 ends the list
2_0_4000111_111
2_0_4044000_111
2_0_5008222_222
2_0_504c000_222
2_0_8010333_333
2_0_8054000_333
2_0_9018444_444
2_0_905c000_444
2_1_4121a5a_a5a
2_1_4165000_a5a
2_1_51295a5_5a5
2_1_516d000_5a5
2_1_8131f0f_f0f
2_1_8175000_f0f
2_1_91390f0_0f0
2_1_917d000_0f0
3_0_9082800_800
3_0_9086900_100
3_0_908a7ff_8ff
3_1_418ffff_fff
3_1_4193002_001
3_1_4197abc_abd

//--- list.f
noc_pkg.sv
mesh_router.sv
tile_endpoint.sv
tile_node.sv
mesh_stitch.sv
core_complex.sv
core_complex_sva.sv
tb_core_complex.sv

//--- Makefile
# Verilator build, run and lint for the core complex testbench.

VERILATOR ?= verilator
TOP       ?= tb_core_complex
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
